/* rtl/burst_pkg.sv */
`default_nettype none

package burst_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int ADDR_WIDTH  = 32;
    localparam int BEATS_WIDTH = 16;
    localparam int LEN_WIDTH   = 8;

    // bytes moved per beat
    localparam int BEAT_BYTES  = 4;

    // byte address
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    // copy length in beats
    typedef logic [BEATS_WIDTH-1:0] beats_t;
    // burst length, beats minus one
    typedef logic [LEN_WIDTH-1:0]   burst_len_t;

    // arbiter phase
    typedef enum logic {
        arb_read,
        arb_write
    } arb_state_t;

endpackage

`default_nettype wire

/* rtl/copy_command_register.sv */
`timescale 1ns/100ps
`default_nettype none

module copy_command_register (
    input  wire                         clk,
    input  wire                         reset,
    input  wire   burst_pkg::addr_t     cmd_src,
    input  wire   burst_pkg::addr_t     cmd_dst,
    input  wire   burst_pkg::beats_t    cmd_size,
    input  wire   burst_pkg::burst_len_t cmd_max_len,
    input  wire                         cmd_valid,
    output logic                        cmd_ready,
    output burst_pkg::addr_t            rd_base,
    output burst_pkg::addr_t            wr_base,
    output burst_pkg::beats_t           size,
    output burst_pkg::burst_len_t       max_len,
    output logic                        rd_valid,
    input  wire                         rd_ready,
    output logic                        wr_valid,
    input  wire                         wr_ready
);

    logic ready_en;
    logic cmd_fire;

    assign cmd_ready = ready_en && !rd_valid && !wr_valid;
    assign cmd_fire  = cmd_valid && cmd_ready;

    // one dead cycle after reset before the first command
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
        end
    end

    // pending flag per side, zero-length copies never raise them
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
            wr_valid <= 1'b0;
        end else if (cmd_fire) begin
            rd_valid <= (cmd_size != '0);
            wr_valid <= (cmd_size != '0);
        end else begin
            if (rd_ready) begin
                rd_valid <= 1'b0;
            end
            if (wr_ready) begin
                wr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            rd_base <= cmd_src;
            wr_base <= cmd_dst;
            size    <= cmd_size;
            max_len <= cmd_max_len;
        end
    end

endmodule

`default_nettype wire

/* rtl/burst_address_generator.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_address_generator (
    input  wire                          clk,
    input  wire                          reset,

    input  wire   burst_pkg::addr_t      base,
    input  wire   burst_pkg::beats_t     size,
    input  wire   burst_pkg::burst_len_t max_len,
    input  wire                          s_valid,
    output logic                         s_ready,

    output burst_pkg::addr_t             m_addr,
    output burst_pkg::burst_len_t        m_len,
    output logic                         m_last,
    output logic                         m_valid,
    input  wire                          m_ready
);

    // --------------------
    // stage 0
    // --------------------
    burst_pkg::addr_t      st0_base;
    burst_pkg::addr_t      st0_offset;
    burst_pkg::beats_t     st0_remain;
    burst_pkg::burst_len_t st0_max_len;
    logic                  st0_valid;
    logic                  st0_ready;
    logic                  st0_last;
    logic                  st0_fire;
    logic                  s_fire;

    // beats and bytes covered by one full burst
    burst_pkg::beats_t     step_beats;
    burst_pkg::addr_t      step_bytes;

    // length of the closing burst
    burst_pkg::burst_len_t last_len;

    assign step_beats = burst_pkg::beats_t'(st0_max_len) + burst_pkg::beats_t'(1);
    assign step_bytes = burst_pkg::addr_t'(step_beats)
                      * burst_pkg::addr_t'(burst_pkg::BEAT_BYTES);

    // at most one full burst left
    assign st0_last = (st0_remain <= step_beats);
    assign last_len = burst_pkg::burst_len_t'(st0_remain - burst_pkg::beats_t'(1));

    // new command only once the previous copy has left stage 0
    assign s_ready  = !st0_valid;
    assign s_fire   = s_valid && s_ready;

    assign st0_ready = !m_valid || m_ready;
    assign st0_fire  = st0_valid && st0_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid <= 1'b0;
        end else if (s_fire) begin
            st0_valid <= 1'b1;
        end else if (st0_fire) begin
            st0_valid <= !st0_last;
        end
    end

    always_ff @(posedge clk) begin
        if (s_fire) begin
            st0_base    <= base;
            st0_remain  <= size;
            st0_max_len <= max_len;
            st0_offset  <= '0;
        end else if (st0_fire) begin
            // step past one full burst
            st0_offset  <= st0_offset + step_bytes;
            st0_remain  <= st0_remain - step_beats;
        end
    end

    // --------------------
    // stage 1
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (st0_fire) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (st0_fire) begin
            m_addr <= st0_base + st0_offset;
            m_last <= st0_last;
            if (st0_last) begin
                m_len <= last_len;
            end else begin
                m_len <= st0_max_len;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/burst_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_arbiter (
    input  wire                          clk,
    input  wire                          reset,

    // read bursts
    input  wire   burst_pkg::addr_t      rd_addr,
    input  wire   burst_pkg::burst_len_t rd_len,
    input  wire                          rd_last,
    input  wire                          rd_valid,
    output logic                         rd_ready,

    // write bursts
    input  wire   burst_pkg::addr_t      wr_addr,
    input  wire   burst_pkg::burst_len_t wr_len,
    input  wire                          wr_last,
    input  wire                          wr_valid,
    output logic                         wr_ready,

    // memory command port
    output burst_pkg::addr_t             mem_addr,
    output burst_pkg::burst_len_t        mem_len,
    output logic                         mem_write,
    output logic                         mem_last,
    output logic                         mem_valid,
    input  wire                          mem_ready
);

    burst_pkg::arb_state_t state;

    logic out_free;
    logic rd_fire;
    logic wr_fire;

    // last flag of the read burst waiting for its write
    logic pair_last;

    // output register can take a burst in the cycle it drains
    assign out_free = !mem_valid || mem_ready;

    assign rd_ready = (state == burst_pkg::arb_read) && out_free;

    // the write must close the same pair the read opened
    assign wr_ready = (state == burst_pkg::arb_write) && out_free
                   && (wr_last == pair_last);

    assign rd_fire  = rd_valid && rd_ready;
    assign wr_fire  = wr_valid && wr_ready;

    // --------------------
    // read/write FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= burst_pkg::arb_read;
            pair_last <= 1'b0;
        end else begin
            case (state)
                burst_pkg::arb_read: begin
                    if (rd_fire) begin
                        state     <= burst_pkg::arb_write;
                        pair_last <= rd_last;
                    end
                end
                burst_pkg::arb_write: begin
                    if (wr_fire) begin
                        state <= burst_pkg::arb_read;
                    end
                end
                default: begin
                    state <= burst_pkg::arb_read;
                end
            endcase
        end
    end

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else if (rd_fire || wr_fire) begin
            mem_valid <= 1'b1;
        end else if (mem_ready) begin
            mem_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            mem_addr  <= rd_addr;
            mem_len   <= rd_len;
            mem_write <= 1'b0;
            mem_last  <= 1'b0;
        end else if (wr_fire) begin
            mem_addr  <= wr_addr;
            mem_len   <= wr_len;
            mem_write <= 1'b1;
            // end of copy only on the write side
            mem_last  <= wr_last;
        end
    end

endmodule

`default_nettype wire

/* rtl/copy_burst_planner.sv */
`timescale 1ns/100ps
`default_nettype none

module copy_burst_planner (
    input  wire                          clk,
    input  wire                          reset,

    input  wire   burst_pkg::addr_t      cmd_src,
    input  wire   burst_pkg::addr_t      cmd_dst,
    input  wire   burst_pkg::beats_t     cmd_size,
    input  wire   burst_pkg::burst_len_t cmd_max_len,
    input  wire                          cmd_valid,
    output logic                         cmd_ready,

    output burst_pkg::addr_t             mem_addr,
    output burst_pkg::burst_len_t        mem_len,
    output logic                         mem_write,
    output logic                         mem_last,
    output logic                         mem_valid,
    input  wire                          mem_ready
);

    // registered command
    burst_pkg::addr_t      rd_base;
    burst_pkg::addr_t      wr_base;
    burst_pkg::beats_t     size;
    burst_pkg::burst_len_t max_len;
    logic                  rd_cmd_valid;
    logic                  rd_cmd_ready;
    logic                  wr_cmd_valid;
    logic                  wr_cmd_ready;

    // burst streams
    burst_pkg::addr_t      rd_burst_addr;
    burst_pkg::burst_len_t rd_burst_len;
    logic                  rd_burst_last;
    logic                  rd_burst_valid;
    logic                  rd_burst_ready;
    burst_pkg::addr_t      wr_burst_addr;
    burst_pkg::burst_len_t wr_burst_len;
    logic                  wr_burst_last;
    logic                  wr_burst_valid;
    logic                  wr_burst_ready;

    copy_command_register cmd_reg_i (
        .clk(clk), .reset(reset),
        .cmd_src(cmd_src), .cmd_dst(cmd_dst), .cmd_size(cmd_size),
        .cmd_max_len(cmd_max_len), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .rd_base(rd_base), .wr_base(wr_base), .size(size), .max_len(max_len),
        .rd_valid(rd_cmd_valid), .rd_ready(rd_cmd_ready),
        .wr_valid(wr_cmd_valid), .wr_ready(wr_cmd_ready)
    );

    // source side
    burst_address_generator rd_gen_i (
        .clk(clk), .reset(reset),
        .base(rd_base), .size(size), .max_len(max_len),
        .s_valid(rd_cmd_valid), .s_ready(rd_cmd_ready),
        .m_addr(rd_burst_addr), .m_len(rd_burst_len), .m_last(rd_burst_last),
        .m_valid(rd_burst_valid), .m_ready(rd_burst_ready)
    );

    // destination side
    burst_address_generator wr_gen_i (
        .clk(clk), .reset(reset),
        .base(wr_base), .size(size), .max_len(max_len),
        .s_valid(wr_cmd_valid), .s_ready(wr_cmd_ready),
        .m_addr(wr_burst_addr), .m_len(wr_burst_len), .m_last(wr_burst_last),
        .m_valid(wr_burst_valid), .m_ready(wr_burst_ready)
    );

    burst_arbiter arb_i (
        .clk(clk), .reset(reset),
        .rd_addr(rd_burst_addr), .rd_len(rd_burst_len), .rd_last(rd_burst_last),
        .rd_valid(rd_burst_valid), .rd_ready(rd_burst_ready),
        .wr_addr(wr_burst_addr), .wr_len(wr_burst_len), .wr_last(wr_burst_last),
        .wr_valid(wr_burst_valid), .wr_ready(wr_burst_ready),
        .mem_addr(mem_addr), .mem_len(mem_len), .mem_write(mem_write),
        .mem_last(mem_last), .mem_valid(mem_valid), .mem_ready(mem_ready)
    );

endmodule

`default_nettype wire

/* testbench/copy_burst_planner_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module copy_burst_planner_assertions (
    input  wire                          clk,
    input  wire                          reset,
    input  wire   burst_pkg::addr_t      mem_addr,
    input  wire   burst_pkg::burst_len_t mem_len,
    input  wire                          mem_write,
    input  wire                          mem_last,
    input  wire                          mem_valid,
    input  wire                          mem_ready,
    input  wire   burst_pkg::arb_state_t arb_state
);

    // kind of the previous accepted burst, a read comes first
    logic prev_write;

    // assertion failures so far
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_write <= 1'b1;
        end else if (mem_valid && mem_ready) begin
            prev_write <= mem_write;
        end
    end

    // --------------------
    // command port checks
    // --------------------
    no_valid_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !mem_valid)
        else begin
            $error("mem_valid is high while reset is held");
            fail_count++;
        end

    hold_when_stalled: assert property (@(posedge clk) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_len)
                                    && $stable(mem_write) && $stable(mem_last))
        else begin
            $error("command port changed while stalled");
            fail_count++;
        end

    read_write_alternate: assert property (@(posedge clk) disable iff (reset)
        mem_valid && mem_ready |-> mem_write != prev_write)
        else begin
            $error("two bursts of the same kind in a row");
            fail_count++;
        end

    last_on_write_only: assert property (@(posedge clk) disable iff (reset)
        mem_valid && mem_last |-> mem_write)
        else begin
            $error("mem_last set on a read burst");
            fail_count++;
        end

    read_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> arb_state == burst_pkg::arb_read)
        else begin
            $error("arbiter does not start in the read phase");
            fail_count++;
        end

endmodule

`default_nettype wire

/* testbench/copy_burst_planner_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module copy_burst_planner_tb;

    logic                  clk;
    logic                  reset;
    burst_pkg::addr_t      cmd_src;
    burst_pkg::addr_t      cmd_dst;
    burst_pkg::beats_t     cmd_size;
    burst_pkg::burst_len_t cmd_max_len;
    logic                  cmd_valid;
    logic                  cmd_ready;
    burst_pkg::addr_t      mem_addr;
    burst_pkg::burst_len_t mem_len;
    logic                  mem_write;
    logic                  mem_last;
    logic                  mem_valid;
    logic                  mem_ready;

    // command table
    string                 test_name[$];
    burst_pkg::addr_t      test_src[$];
    burst_pkg::addr_t      test_dst[$];
    burst_pkg::beats_t     test_size[$];
    burst_pkg::burst_len_t test_max_len[$];
    logic                  test_stall[$];

    // per test progress
    int                    test_bursts[$];
    int                    test_seen[$];
    int                    test_errors[$];

    // expected bursts in arrival order
    burst_pkg::addr_t      exp_addr[$];
    burst_pkg::burst_len_t exp_len[$];
    logic                  exp_write[$];
    logic                  exp_last[$];
    int                    exp_test[$];

    logic [31:0]           lfsr;
    logic                  table_ready;
    int                    cmds_sent;
    int                    check_count;
    int                    error_count;
    int                    tests_passed;
    int                    cycle_count;
    int                    cycle_limit;

    copy_burst_planner dut_i (
        .clk(clk), .reset(reset),
        .cmd_src(cmd_src), .cmd_dst(cmd_dst), .cmd_size(cmd_size),
        .cmd_max_len(cmd_max_len), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .mem_addr(mem_addr), .mem_len(mem_len), .mem_write(mem_write),
        .mem_last(mem_last), .mem_valid(mem_valid), .mem_ready(mem_ready)
    );

    bind copy_burst_planner copy_burst_planner_assertions assertions_i (
        .clk(clk), .reset(reset),
        .mem_addr(mem_addr), .mem_len(mem_len), .mem_write(mem_write),
        .mem_last(mem_last), .mem_valid(mem_valid), .mem_ready(mem_ready),
        .arb_state(arb_i.state)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic add_test(input string name, input burst_pkg::addr_t src,
                            input burst_pkg::addr_t dst, input burst_pkg::beats_t size,
                            input burst_pkg::burst_len_t max_len, input logic stall);
        test_name.push_back(name);
        test_src.push_back(src);
        test_dst.push_back(dst);
        test_size.push_back(size);
        test_max_len.push_back(max_len);
        test_stall.push_back(stall);
        test_bursts.push_back(0);
        test_seen.push_back(0);
        test_errors.push_back(0);
    endtask

    // split one copy into read/write pairs
    task automatic build_expected(input int idx);
        int                    remain;
        int                    step;
        int                    k;
        burst_pkg::addr_t      offset;
        burst_pkg::burst_len_t blen;
        logic                  is_last;
        remain = int'(test_size[idx]);
        step   = int'(test_max_len[idx]) + 1;
        k      = 0;
        while (remain > 0) begin
            is_last = (remain <= step);
            offset  = burst_pkg::addr_t'(k * step * burst_pkg::BEAT_BYTES);
            if (is_last) begin
                blen = burst_pkg::burst_len_t'(remain - 1);
            end else begin
                blen = test_max_len[idx];
            end
            exp_addr.push_back(test_src[idx] + offset);
            exp_len.push_back(blen);
            exp_write.push_back(1'b0);
            exp_last.push_back(1'b0);
            exp_test.push_back(idx);
            exp_addr.push_back(test_dst[idx] + offset);
            exp_len.push_back(blen);
            exp_write.push_back(1'b1);
            exp_last.push_back(is_last);
            exp_test.push_back(idx);
            test_bursts[idx] += 2;
            remain -= step;
            k++;
        end
    endtask

    task automatic check_value(input int idx, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors[idx]++;
            $display("error %s %s: expected %0h, actual %0h",
                     test_name[idx], field, expected, actual);
        end
    endtask

    task automatic take_burst();
        int idx;
        if (exp_test.size() == 0) begin
            error_count++;
            $display("burst at address %0h arrived with no copy outstanding", mem_addr);
        end else begin
            idx = exp_test.pop_front();
            check_value(idx, "addr", exp_addr.pop_front(), mem_addr);
            check_value(idx, "len", exp_len.pop_front(), mem_len);
            check_value(idx, "write", exp_write.pop_front(), mem_write);
            check_value(idx, "last", exp_last.pop_front(), mem_last);
            test_seen[idx]++;
        end
    endtask

    // mem_ready and the burst it accepts at the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (exp_test.size() > 0 && test_stall[exp_test[0]]) begin
                lfsr      = lfsr_next(lfsr);
                mem_ready = lfsr[0];
            end else begin
                mem_ready = 1'b1;
            end
            if (mem_valid && mem_ready) begin
                take_burst();
            end
        end
    end

    task automatic send_command(input int idx);
        cmd_src     = test_src[idx];
        cmd_dst     = test_dst[idx];
        cmd_size    = test_size[idx];
        cmd_max_len = test_max_len[idx];
        cmd_valid   = 1'b1;
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        cmds_sent++;
        cmd_valid = 1'b0;
    endtask

    task automatic report_test(input int idx);
        while (cmds_sent <= idx || test_seen[idx] < test_bursts[idx]) begin
            @(negedge clk);
        end
        if (test_errors[idx] == 0) begin
            tests_passed++;
            $display("%s: %0d bursts, ok", test_name[idx], test_bursts[idx]);
        end else begin
            $display("%s: %0d bursts, %0d errors", test_name[idx], test_bursts[idx],
                     test_errors[idx]);
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int idx;
        reset        = 1'b1;
        cmd_src      = '0;
        cmd_dst      = '0;
        cmd_size     = '0;
        cmd_max_len  = '0;
        cmd_valid    = 1'b0;
        mem_ready    = 1'b1;
        lfsr         = 32'h22684e0a;
        cmds_sent    = 0;
        check_count  = 0;
        error_count  = 0;
        tests_passed = 0;

        //       name               src            dst            size    max   stall
        add_test("short_single",   32'h0000_1000, 32'h0000_8000, 16'd5,   8'd15,  1'b0);
        add_test("exact_multiple", 32'h0000_2000, 32'h0000_9000, 16'd32,  8'd7,   1'b0);
        add_test("remainder",      32'h3000_0000, 32'h4000_0000, 16'd21,  8'd7,   1'b0);
        add_test("random_stall",   32'h0001_0000, 32'h0002_0000, 16'd50,  8'd3,   1'b1);
        add_test("zero_length",    32'h0000_5000, 32'h0000_6000, 16'd0,   8'd7,   1'b0);
        add_test("after_zero",     32'h0000_7000, 32'h0000_a000, 16'd9,   8'd7,   1'b0);
        add_test("single_beat",    32'h0000_b000, 32'h0000_c000, 16'd6,   8'd0,   1'b0);
        add_test("long_stall",     32'h0010_0000, 32'h0020_0000, 16'd600, 8'd255, 1'b1);
        add_test("one_full_burst", 32'h0000_d000, 32'h0000_e000, 16'd16,  8'd15,  1'b1);

        cycle_limit = 200;
        for (idx = 0; idx < test_name.size(); idx++) begin
            build_expected(idx);
            cycle_limit += 20 * test_bursts[idx];
        end
        table_ready = 1'b1;

        repeat (16) @(negedge clk);
        reset = 1'b0;

        // commands go out back to back while bursts are checked
        fork
            begin
                for (int i = 0; i < test_name.size(); i++) begin
                    send_command(i);
                end
            end
            begin
                for (int i = 0; i < test_name.size(); i++) begin
                    report_test(i);
                end
            end
        join

        // catch stray bursts after the last copy
        repeat (10) @(negedge clk);

        $display("%0d of %0d tests passed, %0d checks, %0d errors, %0d assertion failures",
                 tests_passed, test_name.size(), check_count, error_count,
                 dut_i.assertions_i.fail_count);
        if (error_count == 0 && tests_passed == test_name.size()
                && dut_i.assertions_i.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // run limit from the total burst count
    initial begin
        cycle_count = 0;
        wait (table_ready === 1'b1);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run timed out after %0d cycles with bursts still outstanding", cycle_count);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
rtl/burst_pkg.sv
rtl/copy_command_register.sv
rtl/burst_address_generator.sv
rtl/burst_arbiter.sv
rtl/copy_burst_planner.sv
testbench/copy_burst_planner_assertions.sv
testbench/copy_burst_planner_tb.sv
